// ==== Bender.yml ====
package:
  name: x86_subset_decode

sources:
  - hw/decode_pkg.sv
  - hw/route_decoder.sv
  - hw/length_decoder.sv
  - hw/step_issuer.sv
  - hw/x86_subset_decode.sv
  - target: test
    files:
      - tb/x86_subset_decode_assertions.sv
      - tb/x86_subset_decode_tb.sv

// ==== hw/decode_pkg.sv ====
package decode_pkg;

        localparam int MAX_STEPS = 3;    // most ALU steps any opcode needs

        typedef logic [3:0] reg_code_t;  // destination register of a step
        typedef logic [3:0] src_code_t;  // ALU source of a step
        typedef logic [3:0] len_t;       // instruction length, 0 = illegal

        // second opcode byte, either a modrm or a plain immediate
        typedef union packed {
                struct packed {
                        logic [1:0] mod;
                        logic [2:0] reg_field;
                        logic [2:0] rm;
                } modrm;
                logic [7:0] imm8;
        } op_byte2_t;

        // destination codes
        localparam reg_code_t REG_NONE  = 4'h0;
        localparam reg_code_t REG_ESP   = 4'h1;
        localparam reg_code_t REG_EBP   = 4'h2;
        localparam reg_code_t REG_EAX   = 4'h3;
        localparam reg_code_t REG_EIP   = 4'h4;
        localparam reg_code_t REG_STACK = 4'h5;  // stack access register

        localparam src_code_t SRC_NONE = 4'h0;

        // the source code meaning depends on the step
        localparam src_code_t SRC1_ESP     = 4'h2;  // esp or stack move offset
        localparam src_code_t SRC1_IMM     = 4'h3;
        localparam src_code_t SRC1_ESP_BUS = 4'h4;  // address bus pointed to by esp
        localparam src_code_t SRC1_EBP     = 4'h5;
        localparam src_code_t SRC1_EAX     = 4'h6;

        localparam src_code_t SRC2_EBP       = 4'h1;
        localparam src_code_t SRC2_STACK_OFS = 4'h2;
        localparam src_code_t SRC2_EIP       = 4'h3;
        localparam src_code_t SRC2_IMM       = 4'h4;
        localparam src_code_t SRC2_MEM       = 4'h5;  // stack read data
        localparam src_code_t SRC2_STACK_REG = 4'h6;  // stack access register

        localparam src_code_t SRC3_ESP = 4'h1;
        localparam src_code_t SRC3_EIP = 4'h2;

        // first opcode byte
        localparam logic [7:0] OP_PUSH_EBP     = 8'h55;
        localparam logic [7:0] OP_MOV_RM       = 8'h89;
        localparam logic [7:0] OP_MOV_EAX_IMM  = 8'hb8;
        localparam logic [7:0] OP_POP_EBP      = 8'h5d;
        localparam logic [7:0] OP_RET          = 8'hc3;
        localparam logic [7:0] OP_CALL         = 8'he8;
        localparam logic [7:0] OP_PUSH_IMM8    = 8'h6a;
        localparam logic [7:0] OP_MOV_R_RM     = 8'h8b;
        localparam logic [7:0] OP_GRP1_IMM8    = 8'h83;
        localparam logic [7:0] OP_LEAVE        = 8'hc9;

        // modrm forms that the subset accepts
        localparam logic [7:0] MODRM_SUB_EAX = 8'he8;
        localparam logic [7:0] MODRM_ADD_ESP = 8'hc4;
        localparam logic [2:0] RM_EBP        = 3'd5;

endpackage

// ==== hw/length_decoder.sv ====
module length_decoder
        import decode_pkg::*;
(
        input  logic        reset,
        input  logic        clk2,
        input  logic        ope_valid,
        input  logic [15:0] opcode,
        output len_t        length,
        output logic        decoded_valid
);

        op_byte2_t b2;
        len_t      length_d;

        assign b2 = opcode[7:0];

        always_comb begin
                length_d = 4'd0;  // illegal unless matched below
                case (opcode[15:8])
                OP_PUSH_EBP, OP_POP_EBP, OP_RET, OP_LEAVE: begin
                        length_d = 4'd1;
                end
                OP_MOV_RM, OP_PUSH_IMM8: begin
                        length_d = 4'd2;
                end
                OP_MOV_EAX_IMM, OP_CALL: begin
                        length_d = 4'd5;  // opcode plus imm32 / rel32
                end
                OP_GRP1_IMM8: begin
                        if (b2.imm8 == MODRM_SUB_EAX || b2.imm8 == MODRM_ADD_ESP) begin
                                length_d = 4'd3;
                        end
                end
                OP_MOV_R_RM: begin
                        if (b2.modrm.rm == RM_EBP) begin
                                if (b2.modrm.mod == 2'b01) begin
                                        length_d = 4'd3;  // disp8
                                end else if (b2.modrm.mod == 2'b10) begin
                                        length_d = 4'd6;  // disp32
                                end
                        end
                end
                default: ;
                endcase
        end

        always_ff @(posedge reset or posedge clk2) begin
                if (clk2) begin
                        length        <= 4'd0;
                        decoded_valid <= 1'b0;
                end else begin
                        decoded_valid <= ope_valid;  // one pulse per capture
                        if (ope_valid) begin
                                length <= length_d;
                        end
                end
        end

endmodule

// ==== hw/route_decoder.sv ====
module route_decoder
        import decode_pkg::*;
(
        input  logic        reset,
        input  logic        clk2,
        input  logic        ope_valid,
        input  logic [15:0] opcode,
        output reg_code_t   load_1,
        output reg_code_t   load_2,
        output reg_code_t   load_3,
        output src_code_t   select_1,
        output src_code_t   select_2,
        output src_code_t   select_3
);

        op_byte2_t b2;
        logic      mem_form_ok;  // [ebp+disp8] or [ebp+disp32]
        reg_code_t load_1_d;
        reg_code_t load_2_d;
        reg_code_t load_3_d;
        src_code_t select_1_d;
        src_code_t select_2_d;
        src_code_t select_3_d;

        assign b2 = opcode[7:0];
        assign mem_form_ok = (b2.modrm.rm == RM_EBP) &&
                             (b2.modrm.mod == 2'b01 || b2.modrm.mod == 2'b10);

        always_comb begin
                load_1_d   = REG_NONE;  // unknown forms stay all zero
                load_2_d   = REG_NONE;
                load_3_d   = REG_NONE;
                select_1_d = SRC_NONE;
                select_2_d = SRC_NONE;
                select_3_d = SRC_NONE;
                case (opcode[15:8])
                OP_PUSH_EBP: begin
                        load_1_d   = REG_ESP;
                        select_1_d = SRC1_ESP;
                        load_2_d   = REG_ESP;
                        select_2_d = SRC2_EBP;
                end
                OP_MOV_RM: begin
                        load_1_d   = REG_EBP;
                        select_1_d = SRC1_ESP;
                end
                OP_MOV_EAX_IMM: begin
                        load_1_d   = REG_EAX;
                        select_1_d = SRC1_IMM;
                end
                OP_POP_EBP: begin
                        load_1_d   = REG_EBP;
                        select_1_d = SRC1_ESP_BUS;
                        load_2_d   = REG_EBP;
                        select_2_d = SRC2_STACK_OFS;
                end
                OP_RET: begin
                        load_1_d   = REG_EIP;
                        select_1_d = SRC1_ESP_BUS;
                        load_2_d   = REG_EBP;
                        select_2_d = SRC2_STACK_OFS;
                end
                OP_CALL: begin  // push return address, then jump
                        load_1_d   = REG_ESP;
                        select_1_d = SRC1_ESP;
                        load_2_d   = REG_ESP;
                        select_2_d = SRC2_EIP;
                        load_3_d   = REG_EIP;
                        select_3_d = SRC3_EIP;
                end
                OP_PUSH_IMM8: begin
                        load_1_d   = REG_ESP;
                        select_1_d = SRC1_ESP;
                        load_2_d   = REG_ESP;
                        select_2_d = SRC2_IMM;
                end
                OP_MOV_R_RM: begin
                        if (mem_form_ok) begin
                                load_1_d   = REG_STACK;  // address from ebp+disp
                                select_1_d = SRC1_EBP;
                                load_2_d   = REG_EAX;
                                select_2_d = SRC2_STACK_REG;
                        end
                end
                OP_GRP1_IMM8: begin
                        if (b2.imm8 == MODRM_SUB_EAX) begin
                                load_1_d   = REG_EAX;
                                select_1_d = SRC1_EAX;
                        end else if (b2.imm8 == MODRM_ADD_ESP) begin
                                load_1_d   = REG_ESP;
                                select_1_d = SRC1_ESP;
                        end
                end
                OP_LEAVE: begin  // esp <- ebp, then pop ebp
                        load_1_d   = REG_ESP;
                        select_1_d = SRC1_EBP;
                        load_2_d   = REG_STACK;
                        select_2_d = SRC2_MEM;
                        load_3_d   = REG_EBP;
                        select_3_d = SRC3_ESP;
                end
                default: ;
                endcase
        end

        always_ff @(posedge reset or posedge clk2) begin
                if (clk2) begin
                        load_1   <= REG_NONE;
                        load_2   <= REG_NONE;
                        load_3   <= REG_NONE;
                        select_1 <= SRC_NONE;
                        select_2 <= SRC_NONE;
                        select_3 <= SRC_NONE;
                end else if (ope_valid) begin  // hold until next capture
                        load_1   <= load_1_d;
                        load_2   <= load_2_d;
                        load_3   <= load_3_d;
                        select_1 <= select_1_d;
                        select_2 <= select_2_d;
                        select_3 <= select_3_d;
                end
        end

endmodule

// ==== hw/step_issuer.sv ====
module step_issuer
        import decode_pkg::*;
#(
        parameter int unsigned          eip_width = 32,
        parameter logic [eip_width-1:0] reset_eip = '0
) (
        input  logic                 reset,
        input  logic                 clk2,
        input  logic                 decoded_valid,
        input  len_t                 length,
        input  reg_code_t            load_1,
        input  reg_code_t            load_2,
        input  reg_code_t            load_3,
        input  src_code_t            select_1,
        input  src_code_t            select_2,
        input  src_code_t            select_3,
        output logic                 step_valid,
        output reg_code_t            step_load,
        output src_code_t            step_select,
        output logic                 last_step,
        output logic                 illegal,
        output logic                 busy,
        output logic [eip_width-1:0] eip
);

        localparam int cnt_width = $clog2(MAX_STEPS + 1);

        logic [cnt_width-1:0] step_count;  // steps the new opcode needs
        logic [cnt_width-1:0] remaining;   // steps left after the current one
        len_t                 length_q;
        reg_code_t            load_2_q;
        reg_code_t            load_3_q;
        src_code_t            select_2_q;
        src_code_t            select_3_q;

        always_comb begin
                if (load_3 != REG_NONE) begin
                        step_count = cnt_width'(3);
                end else if (load_2 != REG_NONE) begin
                        step_count = cnt_width'(2);
                end else if (load_1 != REG_NONE) begin
                        step_count = cnt_width'(1);
                end else begin
                        step_count = '0;
                end
        end

        // pending step codes, shifted forward one per step
        always_ff @(posedge reset) begin
                if (decoded_valid) begin
                        length_q   <= length;
                        load_2_q   <= load_2;
                        load_3_q   <= load_3;
                        select_2_q <= select_2;
                        select_3_q <= select_3;
                end else if (step_valid) begin
                        load_2_q   <= load_3_q;
                        select_2_q <= select_3_q;
                end
        end

        always_ff @(posedge reset or posedge clk2) begin
                if (clk2) begin
                        step_valid  <= 1'b0;
                        step_load   <= REG_NONE;
                        step_select <= SRC_NONE;
                        last_step   <= 1'b0;
                        illegal     <= 1'b0;
                        busy        <= 1'b0;
                        remaining   <= '0;
                        eip         <= reset_eip;
                end else begin
                        illegal <= 1'b0;
                        if (decoded_valid) begin
                                if (length == 4'd0) begin
                                        illegal <= 1'b1;  // no steps, eip kept
                                end else begin
                                        step_valid  <= 1'b1;  // step 1 right away
                                        step_load   <= load_1;
                                        step_select <= select_1;
                                        busy        <= 1'b1;
                                        last_step   <= (step_count == cnt_width'(1));
                                        remaining   <= step_count - cnt_width'(1);
                                end
                        end else if (step_valid) begin
                                if (last_step) begin
                                        step_valid <= 1'b0;
                                        busy       <= 1'b0;
                                        last_step  <= 1'b0;
                                        eip        <= eip + eip_width'(length_q);
                                end else begin
                                        step_load   <= load_2_q;
                                        step_select <= select_2_q;
                                        last_step   <= (remaining == cnt_width'(1));
                                        remaining   <= remaining - cnt_width'(1);
                                end
                        end
                end
        end

endmodule

// ==== hw/x86_subset_decode.sv ====
module x86_subset_decode
        import decode_pkg::*;
#(
        parameter int unsigned          eip_width = 32,
        parameter logic [eip_width-1:0] reset_eip = '0
) (
        input  logic                 reset,
        input  logic                 clk2,
        input  logic [31:0]          ope,
        input  logic                 ope_valid,
        output logic                 step_valid,
        output reg_code_t            step_load,
        output src_code_t            step_select,
        output logic                 last_step,
        output logic                 illegal,
        output logic                 busy,
        output logic [eip_width-1:0] eip
);

        reg_code_t load_1;
        reg_code_t load_2;
        reg_code_t load_3;
        src_code_t select_1;
        src_code_t select_2;
        src_code_t select_3;
        len_t      length;
        logic      decoded_valid;

        // only the top two opcode bytes carry decode information
        route_decoder u_route_decoder (
                .reset     (reset),
                .clk2      (clk2),
                .ope_valid (ope_valid),
                .opcode    (ope[31:16]),
                .load_1    (load_1),
                .load_2    (load_2),
                .load_3    (load_3),
                .select_1  (select_1),
                .select_2  (select_2),
                .select_3  (select_3)
        );

        length_decoder u_length_decoder (
                .reset         (reset),
                .clk2          (clk2),
                .ope_valid     (ope_valid),
                .opcode        (ope[31:16]),
                .length        (length),
                .decoded_valid (decoded_valid)
        );

        step_issuer #(
                .eip_width (eip_width),
                .reset_eip (reset_eip)
        ) u_step_issuer (
                .reset         (reset),
                .clk2          (clk2),
                .decoded_valid (decoded_valid),
                .length        (length),
                .load_1        (load_1),
                .load_2        (load_2),
                .load_3        (load_3),
                .select_1      (select_1),
                .select_2      (select_2),
                .select_3      (select_3),
                .step_valid    (step_valid),
                .step_load     (step_load),
                .step_select   (step_select),
                .last_step     (last_step),
                .illegal       (illegal),
                .busy          (busy),
                .eip           (eip)
        );

endmodule

// ==== list.f ====
hw/decode_pkg.sv
hw/route_decoder.sv
hw/length_decoder.sv
hw/step_issuer.sv
hw/x86_subset_decode.sv
tb/x86_subset_decode_assertions.sv
tb/x86_subset_decode_tb.sv

// ==== tb/decode_stimulus.txt ====
# opcode word (ope[31:16]), length, step count, then load and select
# codes of steps 1, 2 and 3; all values hex, length 0 means illegal
5500 1 2 1 2 1 1 0 0
89e5 2 1 2 2 0 0 0 0
b801 5 1 3 3 0 0 0 0
5d00 1 2 2 4 2 2 0 0
c300 1 2 4 4 2 2 0 0
e800 5 3 1 2 1 3 4 2
6a08 2 2 1 2 1 4 0 0
8b45 3 2 5 5 3 6 0 0
8b85 6 2 5 5 3 6 0 0
83e8 3 1 3 6 0 0 0 0
83c4 3 1 1 2 0 0 0 0
c9ff 1 3 1 5 5 5 2 1
8b44 0 0 0 0 0 0 0 0
8bc5 0 0 0 0 0 0 0 0
8b05 0 0 0 0 0 0 0 0
83c0 0 0 0 0 0 0 0 0
83e9 0 0 0 0 0 0 0 0
9090 0 0 0 0 0 0 0 0
e2fe 0 0 0 0 0 0 0 0
0000 0 0 0 0 0 0 0 0
ffff 0 0 0 0 0 0 0 0
8b4d 3 2 5 5 3 6 0 0
8b95 6 2 5 5 3 6 0 0
c955 1 3 1 5 5 5 2 1
55e5 1 2 1 2 1 1 0 0
5dc3 1 2 2 4 2 2 0 0
c3ff 1 2 4 4 2 2 0 0
e8ab 5 3 1 2 1 3 4 2
6aff 2 2 1 2 1 4 0 0
89ec 2 1 2 2 0 0 0 0
b8ff 5 1 3 3 0 0 0 0
8b84 0 0 0 0 0 0 0 0
83c4 3 1 1 2 0 0 0 0
83e8 3 1 3 6 0 0 0 0
8b6d 3 2 5 5 3 6 0 0
c4e8 0 0 0 0 0 0 0 0
55aa 1 2 1 2 1 1 0 0
e800 5 3 1 2 1 3 4 2

// ==== tb/x86_subset_decode_assertions.sv ====
module x86_subset_decode_assertions (
        input logic       reset,
        input logic       clk2,
        input logic       decoded_valid,
        input logic [3:0] length,
        input logic [3:0] load_1,
        input logic       step_valid,
        input logic [3:0] step_load,
        input logic       illegal,
        input logic       busy
);
        timeunit 1ns;
        timeprecision 1ps;

        // a new opcode must not reach the issuer while steps are still playing out
        no_decode_while_busy: assert property (@(posedge reset) disable iff (clk2)
                        !(decoded_valid && busy))
                else $error("opcode decoded while the step issuer was busy");

        // every issued step writes some register
        step_loads_register: assert property (@(posedge reset) disable iff (clk2)
                        step_valid |-> step_load != 4'h0)
                else $error("step strobe with no destination register");

        // both decoders agree on which forms are legal
        decoders_agree: assert property (@(posedge reset) disable iff (clk2)
                        decoded_valid |-> ((length == 4'd0) == (load_1 == 4'h0)))
                else $error("length and route decoders disagree on legality");

        illegal_excludes_step: assert property (@(posedge reset) disable iff (clk2)
                        !(illegal && step_valid))
                else $error("illegal pulse together with a step strobe");

endmodule

bind step_issuer x86_subset_decode_assertions u_assertions (
        .reset         (reset),
        .clk2          (clk2),
        .decoded_valid (decoded_valid),
        .length        (length),
        .load_1        (load_1),
        .step_valid    (step_valid),
        .step_load     (step_load),
        .illegal       (illegal),
        .busy          (busy)
);

// ==== tb/x86_subset_decode_tb.sv ====
module x86_subset_decode_tb
        import decode_pkg::*;
();
        timeunit 1ns;
        timeprecision 1ps;

        localparam int                   ope_width      = 32;
        localparam int                   eip_width      = 32;
        localparam logic [eip_width-1:0] start_eip      = 32'h0040_1000;
        localparam int                   max_vec        = 64;
        localparam int                   response_limit = 12;  // cycles per opcode
        localparam logic [31:0]          lfsr_seed      = 32'd90089;

        logic                 reset;  // clock
        logic                 clk2;   // async reset, active high
        logic [ope_width-1:0] ope;
        logic                 ope_valid;
        logic                 step_valid;
        reg_code_t            step_load;
        src_code_t            step_select;
        logic                 last_step;
        logic                 illegal;
        logic                 busy;
        logic [eip_width-1:0] eip;

        logic [15:0] op_mem   [0:max_vec-1];
        logic [3:0]  len_mem  [0:max_vec-1];
        int          steps_mem[0:max_vec-1];
        logic [3:0]  load_mem [0:max_vec-1][0:MAX_STEPS-1];
        logic [3:0]  sel_mem  [0:max_vec-1][0:MAX_STEPS-1];

        int                   n_vec = 0;
        int                   errors = 0;
        bit                   stimulus_loaded = 1'b0;
        logic [31:0]          lfsr;
        logic [eip_width-1:0] eip_exp;  // running eip model

        x86_subset_decode #(
                .eip_width (eip_width),
                .reset_eip (start_eip)
        ) u_dut (
                .reset       (reset),
                .clk2        (clk2),
                .ope         (ope),
                .ope_valid   (ope_valid),
                .step_valid  (step_valid),
                .step_load   (step_load),
                .step_select (step_select),
                .last_step   (last_step),
                .illegal     (illegal),
                .busy        (busy),
                .eip         (eip)
        );

        initial begin
                reset = 1'b0;
                forever #10 reset = ~reset;  // 20 ns period
        end

        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                if (s[0]) begin
                        return (s >> 1) ^ 32'h8020_0003;  // x^32+x^22+x^2+x+1
                end
                return s >> 1;
        endfunction

        task automatic draw_random_bits(output logic [15:0] bits);
                int i;
                bits = '0;
                for (i = 0; i < 16; i++) begin
                        lfsr = lfsr_step(lfsr);
                        bits = {bits[14:0], lfsr[0]};
                end
        endtask

        task automatic log_wrong_value(input string name, input string what,
                                       input logic [31:0] expv, input logic [31:0] act);
                $display("Mismatch %s %s: expected %0h actual %0h", name, what, expv, act);
                errors++;
        endtask

        task automatic log_failure(input string text);
                $display("Error: %s", text);
                errors++;
        endtask

        task automatic load_stimulus();
                int             fd;
                int             code;
                reg [8*256-1:0] line;
                logic [31:0]    v_op, v_len, v_steps;
                logic [31:0]    v_l1, v_s1, v_l2, v_s2, v_l3, v_s3;
                fd = $fopen("tb/decode_stimulus.txt", "r");
                if (fd == 0) begin
                        log_failure("cannot open tb/decode_stimulus.txt");
                        return;
                end
                while (!$feof(fd) && n_vec < max_vec) begin
                        line = '0;
                        code = $fgets(line, fd);
                        if (code > 0) begin
                                code = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                               v_op, v_len, v_steps,
                                               v_l1, v_s1, v_l2, v_s2, v_l3, v_s3);
                                if (code == 9) begin  // comment and blank lines skipped
                                        op_mem[n_vec]      = v_op[15:0];
                                        len_mem[n_vec]     = v_len[3:0];
                                        steps_mem[n_vec]   = v_steps;
                                        load_mem[n_vec][0] = v_l1[3:0];
                                        sel_mem[n_vec][0]  = v_s1[3:0];
                                        load_mem[n_vec][1] = v_l2[3:0];
                                        sel_mem[n_vec][1]  = v_s2[3:0];
                                        load_mem[n_vec][2] = v_l3[3:0];
                                        sel_mem[n_vec][2]  = v_s3[3:0];
                                        n_vec++;
                                end
                        end
                end
                $fclose(fd);
                if (n_vec == 0) begin
                        log_failure("stimulus file holds no entries");
                end
        endtask

        task automatic check_idle_after_reset();
                int c;
                for (c = 0; c < 2; c++) begin
                        @(negedge reset);
                        if (step_valid !== 1'b0)
                                log_wrong_value("after_reset", "step_valid", 0, step_valid);
                        if (last_step !== 1'b0)
                                log_wrong_value("after_reset", "last_step", 0, last_step);
                        if (illegal !== 1'b0)
                                log_wrong_value("after_reset", "illegal", 0, illegal);
                        if (busy !== 1'b0)
                                log_wrong_value("after_reset", "busy", 0, busy);
                        if (eip !== start_eip)
                                log_wrong_value("after_reset", "eip", start_eip, eip);
                end
        endtask

        task automatic check_response(input int idx, input string name);
                int                   cyc;
                int                   seen;
                int                   finish_cyc;
                int                   steps;
                bit                   legal;
                bit                   exp_step;
                bit                   exp_illegal;
                logic [eip_width-1:0] eip_after;
                logic [eip_width-1:0] exp_eip;
                steps      = steps_mem[idx];
                legal      = (len_mem[idx] != 4'd0);
                eip_after  = legal ? eip_exp + eip_width'(len_mem[idx]) : eip_exp;
                cyc        = 0;
                seen       = 0;
                finish_cyc = 0;
                while ((finish_cyc == 0 || cyc < finish_cyc) && cyc < response_limit) begin
                        @(negedge reset);
                        cyc++;
                        exp_step    = legal && cyc >= 2 && cyc <= steps + 1;
                        exp_illegal = !legal && cyc == 2;
                        exp_eip     = (legal && cyc >= steps + 2) ? eip_after : eip_exp;
                        if (step_valid !== exp_step)
                                log_wrong_value(name, $sformatf("cycle %0d step_valid", cyc),
                                                exp_step, step_valid);
                        if (busy !== exp_step)
                                log_wrong_value(name, $sformatf("cycle %0d busy", cyc),
                                                exp_step, busy);
                        if (illegal !== exp_illegal)
                                log_wrong_value(name, $sformatf("cycle %0d illegal", cyc),
                                                exp_illegal, illegal);
                        if (eip !== exp_eip)
                                log_wrong_value(name, $sformatf("cycle %0d eip", cyc),
                                                exp_eip, eip);
                        if (step_valid === 1'b1) begin
                                if (seen < MAX_STEPS) begin
                                        if (step_load !== load_mem[idx][seen])
                                                log_wrong_value(name,
                                                        $sformatf("step %0d load", seen + 1),
                                                        load_mem[idx][seen], step_load);
                                        if (step_select !== sel_mem[idx][seen])
                                                log_wrong_value(name,
                                                        $sformatf("step %0d select", seen + 1),
                                                        sel_mem[idx][seen], step_select);
                                        if (last_step !== (seen + 1 == steps))
                                                log_wrong_value(name,
                                                        $sformatf("step %0d last_step", seen + 1),
                                                        (seen + 1 == steps), last_step);
                                end
                                seen++;
                                if (last_step === 1'b1) begin
                                        finish_cyc = cyc + 1;  // eip shows up next cycle
                                end
                        end
                        if (illegal === 1'b1) begin
                                finish_cyc = cyc + 1;
                        end
                end
                if (finish_cyc == 0 || cyc < finish_cyc)
                        log_failure($sformatf("%s got no last step or illegal pulse in %0d cycles",
                                              name, response_limit));
                if (seen != steps)
                        log_wrong_value(name, "step count", steps, seen);
                eip_exp = eip_after;
        endtask

        task automatic run_instruction(input int idx);
                string       name;
                logic [15:0] low;
                name = $sformatf("vec%0d_op%04h", idx, op_mem[idx]);
                draw_random_bits(low);  // low half must not matter
                @(posedge reset);
                ope       <= {op_mem[idx], low};
                ope_valid <= 1'b1;
                @(posedge reset);
                ope_valid <= 1'b0;
                check_response(idx, name);
                repeat (2) @(posedge reset);
        endtask

        initial begin
                int i;
                ope       = '0;
                ope_valid = 1'b0;
                clk2      = 1'b1;
                lfsr      = lfsr_seed;
                eip_exp   = start_eip;
                load_stimulus();
                stimulus_loaded = 1'b1;
                repeat (4) @(posedge reset);
                clk2 <= 1'b0;
                check_idle_after_reset();
                for (i = 0; i < n_vec; i++) begin
                        run_instruction(i);
                end
                $display("instructions: %0d  errors: %0d", n_vec, errors);
                if (errors == 0) begin
                        $display("Test OK");
                end else begin
                        $display("Test FAILED");
                end
                $finish;
        end

        initial begin
                wait (stimulus_loaded);
                repeat (n_vec * 10 + 100) @(posedge reset);
                $display("Error: timeout, the run did not complete within %0d cycles",
                         n_vec * 10 + 100);
                $display("Test FAILED");
                $finish;
        end

endmodule
